//--- filelist.f
source/ppu_pkg.sv
source/core_add_sub.sv
source/core_mul.sv
source/core_div.sv
source/core_fma_accumulator.sv
source/core_op.sv
verification/core_op_asserts.sv
verification/core_op_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module core_op_tb \
  -f filelist.f -o core_op_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/core_op_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation passed"
exit 0

//--- source/core_add_sub.sv
`timescale 1ns/1ps

module core_add_sub (
  input  logic                                     sub_i,
  input  ppu_pkg::fir_t                            a_i,
  input  ppu_pkg::fir_t                            b_i,
  output ppu_pkg::unit_result_t                    res_o,
  output logic [ppu_pkg::MANT_ADD_RESULT_SIZE-1:0] mant_o
);

  ppu_pkg::fir_t                                op_big;
  ppu_pkg::fir_t                                op_small;
  logic                                         a_larger;
  logic                                         eff_sub;
  logic                                         sticky;
  logic [ppu_pkg::MANT_ADD_RESULT_SIZE-1:0]     big_m;
  logic [ppu_pkg::MANT_ADD_RESULT_SIZE-1:0]     small_m;
  logic [ppu_pkg::MANT_ADD_RESULT_SIZE-1:0]     sum;
  logic [2*ppu_pkg::MANT_ADD_RESULT_SIZE-1:0]   shifted;

  assign a_larger = (a_i.total_exponent > b_i.total_exponent) ||
                    ((a_i.total_exponent == b_i.total_exponent) && (a_i.mant >= b_i.mant));

  assign op_big   = a_larger ? a_i : b_i;
  assign op_small = a_larger ? b_i : a_i;
  assign eff_sub  = a_i.sign ^ b_i.sign ^ sub_i;
  assign big_m    = {1'b0, op_big.mant, 1'b0};  // One guard bit.

  // Alignment and add.
  always_comb begin
    int diff;
    diff    = int'(op_big.total_exponent) - int'(op_small.total_exponent);
    shifted = {1'b0, op_small.mant, 1'b0, {ppu_pkg::MANT_ADD_RESULT_SIZE{1'b0}}} >> diff;
    if (diff >= 2*ppu_pkg::MANT_ADD_RESULT_SIZE - 1) begin
      small_m = '0;
      sticky  = 1'b1;  // Whole operand shifted out.
    end else begin
      small_m = shifted[2*ppu_pkg::MANT_ADD_RESULT_SIZE-1:ppu_pkg::MANT_ADD_RESULT_SIZE];
      sticky  = |shifted[ppu_pkg::MANT_ADD_RESULT_SIZE-1:0];
    end
    if (eff_sub) begin
      sum = big_m - small_m;
      if (sticky) begin
        sum = sum - 1'b1;  // Borrow from the dropped bits.
      end
    end else begin
      sum = big_m + small_m;
    end
  end

  // Normalize to 01.x at the top.
  always_comb begin
    int lead;
    int shl;
    lead = 0;
    for (int i = 0; i < ppu_pkg::MANT_ADD_RESULT_SIZE; i++) begin
      if (sum[i]) begin
        lead = i;
      end
    end
    shl        = ppu_pkg::MANT_ADD_RESULT_SIZE - 2 - lead;
    res_o.sign = a_larger ? a_i.sign : (b_i.sign ^ sub_i);
    if (sum[ppu_pkg::MANT_ADD_RESULT_SIZE-1]) begin
      mant_o               = sum >> 1;  // Carry out.
      res_o.te             = op_big.total_exponent + ppu_pkg::exponent_t'(1);
      res_o.frac_truncated = sticky | sum[0];
    end else begin
      mant_o               = sum << shl;
      res_o.te             = op_big.total_exponent - ppu_pkg::exponent_t'(shl);
      res_o.frac_truncated = sticky;
    end
  end

endmodule

//--- source/core_div.sv
`timescale 1ns/1ps

module core_div (
  input  ppu_pkg::fir_t         a_i,
  input  ppu_pkg::fir_t         b_i,
  output ppu_pkg::unit_result_t res_o,
  output ppu_pkg::frac_full_t   mant_o
);

  logic                          a_lt_b;
  logic [ppu_pkg::MANT_SIZE:0]   dividend;
  logic [ppu_pkg::MANT_SIZE+1:0] divisor;
  logic [ppu_pkg::MANT_SIZE+1:0] rem;

  assign a_lt_b   = a_i.mant < b_i.mant;
  assign dividend = a_lt_b ? {a_i.mant, 1'b0} : {1'b0, a_i.mant};  // Quotient in [1,2).
  assign divisor  = {2'b00, b_i.mant};

  // Restoring division, one quotient bit per step.
  always_comb begin
    rem = {1'b0, dividend} - divisor;  // Integer bit, always one.
    rem = rem << 1;
    for (int i = ppu_pkg::FRAC_FULL_SIZE - 1; i >= 0; i--) begin
      if (rem >= divisor) begin
        mant_o[i] = 1'b1;
        rem       = rem - divisor;
      end else begin
        mant_o[i] = 1'b0;
      end
      rem = rem << 1;
    end
  end

  always_comb begin
    res_o.sign           = a_i.sign ^ b_i.sign;
    res_o.te             = a_i.total_exponent - b_i.total_exponent
                         - ppu_pkg::exponent_t'(a_lt_b);
    res_o.frac_truncated = |rem;  // Inexact quotient.
  end

endmodule

//--- source/core_fma_accumulator.sv
`timescale 1ns/1ps

module core_fma_accumulator (
  input  logic                                     clk_i,
  input  logic                                     rst_i,
  input  ppu_pkg::operation_e                      op_i,
  input  ppu_pkg::unit_result_t                    prod_i,
  input  logic [ppu_pkg::MANT_MUL_RESULT_SIZE-1:0] prod_mant_i,
  input  ppu_pkg::fir_t                            addend_i,
  output ppu_pkg::unit_result_t                    res_o,
  output ppu_pkg::frac_full_t                      frac_o
);

  ppu_pkg::quire_t          quire_q;
  logic                     chain_q;   // Previous op was FMADD.
  ppu_pkg::quire_t          prod_fx;
  ppu_pkg::quire_t          addend_fx;
  logic [ppu_pkg::FX_B-1:0] mag;
  logic [ppu_pkg::FX_B-1:0] norm;

  function automatic ppu_pkg::quire_t to_quire(
    input logic                     sign,
    input ppu_pkg::exponent_t       te,
    input logic [ppu_pkg::FX_B-1:0] mant,
    input int                       frac_bits
  );
    int                       shift;
    logic [ppu_pkg::FX_B-1:0] aligned;
    shift = int'(te) + ppu_pkg::FX_M - frac_bits;
    if (shift >= 0) begin
      aligned = mant << shift;
    end else begin
      aligned = mant >> (-shift);
    end
    return sign ? -$signed(aligned) : $signed(aligned);
  endfunction

  // Dropped product bit goes back in as the LSB.
  assign prod_fx = to_quire(prod_i.sign, prod_i.te,
    {{(ppu_pkg::FX_B-ppu_pkg::MANT_MUL_RESULT_SIZE-1){1'b0}}, prod_mant_i,
     prod_i.frac_truncated},
    ppu_pkg::MANT_MUL_RESULT_SIZE - 1);

  assign addend_fx = to_quire(addend_i.sign, addend_i.total_exponent,
    {{(ppu_pkg::FX_B-ppu_pkg::MANT_SIZE){1'b0}}, addend_i.mant},
    ppu_pkg::MANT_SIZE - 1);

  // ==========================================================
  // Quire register
  // ==========================================================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      quire_q <= '0;
      chain_q <= 1'b0;
    end else begin
      chain_q <= (op_i == ppu_pkg::FMADD);
      if (op_i == ppu_pkg::FMADD) begin
        quire_q <= chain_q ? (quire_q + prod_fx) : (prod_fx + addend_fx);
      end
    end
  end

  // ==========================================================
  // Readback normalization
  // ==========================================================

  assign mag = quire_q[ppu_pkg::FX_B-1] ? -quire_q : quire_q;

  always_comb begin
    int lead;
    lead = 0;
    for (int i = 0; i < ppu_pkg::FX_B; i++) begin
      if (mag[i]) begin
        lead = i;
      end
    end
    norm                 = mag << (ppu_pkg::FX_B - 1 - lead);  // Leading one to the MSB.
    frac_o               = norm[ppu_pkg::FX_B-2 -: ppu_pkg::FRAC_FULL_SIZE];
    res_o.sign           = quire_q[ppu_pkg::FX_B-1];
    res_o.te             = ppu_pkg::exponent_t'(lead - ppu_pkg::FX_M);
    res_o.frac_truncated = |norm[ppu_pkg::FX_B-ppu_pkg::FRAC_FULL_SIZE-2:0];
  end

endmodule

//--- source/core_mul.sv
`timescale 1ns/1ps

module core_mul (
  input  ppu_pkg::fir_t                            a_i,
  input  ppu_pkg::fir_t                            b_i,
  output ppu_pkg::unit_result_t                    res_o,
  output logic [ppu_pkg::MANT_MUL_RESULT_SIZE-1:0] mant_o
);

  logic [ppu_pkg::MANT_MUL_RESULT_SIZE-1:0] prod;
  logic                                     ovf;

  assign prod = a_i.mant * b_i.mant;
  assign ovf  = prod[ppu_pkg::MANT_MUL_RESULT_SIZE-1];  // Product reached 2.0.

  always_comb begin
    res_o.sign           = a_i.sign ^ b_i.sign;
    res_o.te             = a_i.total_exponent + b_i.total_exponent
                         + ppu_pkg::exponent_t'(ovf);
    res_o.frac_truncated = ovf & prod[0];
    mant_o               = ovf ? (prod >> 1) : prod;
  end

endmodule

//--- source/core_op.sv
`timescale 1ns/1ps

module core_op (
  input  logic                clk_i,
  input  logic                rst_i,
  input  ppu_pkg::operation_e op_i,
  input  ppu_pkg::fir_t       fir1_i,
  input  ppu_pkg::fir_t       fir2_i,
  input  ppu_pkg::fir_t       fir3_i,
  output logic                sign_o,
  output ppu_pkg::exponent_t  te_o,
  output ppu_pkg::frac_full_t frac_o,
  output logic                frac_truncated_o
);

  ppu_pkg::unit_result_t                    res_add_sub;
  ppu_pkg::unit_result_t                    res_mul;
  ppu_pkg::unit_result_t                    res_div;
  ppu_pkg::unit_result_t                    res_fma;
  ppu_pkg::unit_result_t                    sel;
  logic [ppu_pkg::MANT_ADD_RESULT_SIZE-1:0] mant_add_sub;
  logic [ppu_pkg::MANT_MUL_RESULT_SIZE-1:0] mant_mul;
  logic [ppu_pkg::MANT_DIV_RESULT_SIZE-1:0] mant_div;
  ppu_pkg::frac_full_t                      frac_fma;
  ppu_pkg::frac_full_t                      frac_add_sub;
  ppu_pkg::frac_full_t                      frac_mul;
  logic                                     is_fmadd;
  ppu_pkg::unit_result_t                    prod_fma;
  logic [ppu_pkg::MANT_MUL_RESULT_SIZE-1:0] prod_mant_fma;
  ppu_pkg::fir_t                            addend_fma;

  core_add_sub u_add_sub (
    .sub_i  (op_i == ppu_pkg::SUB),
    .a_i    (fir1_i),
    .b_i    (fir2_i),
    .res_o  (res_add_sub),
    .mant_o (mant_add_sub)
  );

  core_mul u_mul (
    .a_i    (fir1_i),
    .b_i    (fir2_i),
    .res_o  (res_mul),
    .mant_o (mant_mul)
  );

  core_div u_div (
    .a_i    (fir1_i),
    .b_i    (fir2_i),
    .res_o  (res_div),
    .mant_o (mant_div)
  );

  assign is_fmadd      = (op_i == ppu_pkg::FMADD);
  assign prod_fma      = is_fmadd ? res_mul : '0;
  assign prod_mant_fma = is_fmadd ? mant_mul : '0;
  assign addend_fma    = is_fmadd ? fir3_i : '0;  // Used only at chain start.

  core_fma_accumulator u_fma (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .op_i        (op_i),
    .prod_i      (prod_fma),
    .prod_mant_i (prod_mant_fma),
    .addend_i    (addend_fma),
    .res_o       (res_fma),
    .frac_o      (frac_fma)
  );

  // ==========================================================
  // Result alignment and select
  // ==========================================================

  // Integer bits shift out at the top.
  assign frac_add_sub = ppu_pkg::frac_full_t'(mant_add_sub)
                      << (ppu_pkg::FRAC_FULL_SIZE - ppu_pkg::MANT_ADD_RESULT_SIZE + 2);
  assign frac_mul     = ppu_pkg::frac_full_t'(mant_mul)
                      << (ppu_pkg::FRAC_FULL_SIZE - ppu_pkg::MANT_MUL_RESULT_SIZE + 2);

  always_comb begin
    case (op_i)
      ppu_pkg::ADD, ppu_pkg::SUB: begin
        sel    = res_add_sub;
        frac_o = frac_add_sub;
      end
      ppu_pkg::MUL: begin
        sel    = res_mul;
        frac_o = frac_mul;
      end
      ppu_pkg::DIV: begin
        sel    = res_div;
        frac_o = mant_div;
      end
      default: begin
        sel    = res_fma;  // FMADD and FMREAD.
        frac_o = frac_fma;
      end
    endcase
  end

  assign sign_o           = sel.sign;
  assign te_o             = sel.te;
  assign frac_truncated_o = sel.frac_truncated;

endmodule

//--- source/ppu_pkg.sv
package ppu_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================

  localparam int TE_BITS              = 7;   // Signed total exponent.
  localparam int MANT_SIZE            = 13;  // Hidden bit plus twelve fraction bits.
  localparam int FRAC_FULL_SIZE       = 26;  // Output fraction.

  localparam int MANT_ADD_RESULT_SIZE = 15;  // Two integer bits, thirteen fraction bits.
  localparam int MANT_MUL_RESULT_SIZE = 26;  // Two integer bits.
  localparam int MANT_DIV_RESULT_SIZE = 26;  // Fraction bits only.

  localparam int FX_B                 = 64;  // Quire width.
  localparam int FX_M                 = 32;  // Quire fraction bits.

  // ==========================================================
  // Types
  // ==========================================================

  typedef logic signed [TE_BITS-1:0]  exponent_t;
  typedef logic [MANT_SIZE-1:0]       mant_t;
  typedef logic [FRAC_FULL_SIZE-1:0]  frac_full_t;
  typedef logic signed [FX_B-1:0]     quire_t;

  typedef enum logic [2:0] {
    ADD    = 3'd0,
    SUB    = 3'd1,
    MUL    = 3'd2,
    DIV    = 3'd3,
    FMADD  = 3'd4,  // Load or accumulate the quire.
    FMREAD = 3'd5   // Read the quire back.
  } operation_e;

  // Decoded operand.
  typedef struct packed {
    logic      sign;
    exponent_t total_exponent;
    mant_t     mant;             // Hidden bit at the top.
  } fir_t;

  typedef struct packed {
    logic      sign;
    exponent_t te;
    logic      frac_truncated;   // Nonzero bits were dropped.
  } unit_result_t;

endpackage

//--- verification/core_op_asserts.sv
`timescale 1ns/1ps

module core_op_asserts (
  input logic                  clk_i,
  input logic                  rst_i,
  input ppu_pkg::operation_e   op_i,
  input ppu_pkg::quire_t       quire_i,
  input ppu_pkg::unit_result_t res_i
);

  // Reset empties the quire.
  quire_reset_a: assert property (@(posedge clk_i) rst_i |=> (quire_i == '0))
    else $error("quire not zero after reset");

  quire_read_a: assert property (@(posedge clk_i)
      (!rst_i && op_i == ppu_pkg::FMREAD) |=> $stable(quire_i))
    else $error("FMREAD changed the quire");

  // Normalized quire is always defined once out of reset.
  result_known_a: assert property (@(posedge clk_i) disable iff (rst_i)
      !$isunknown(res_i))
    else $error("unknown bits on the accumulator result");

endmodule

bind core_fma_accumulator core_op_asserts u_asserts (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .op_i    (op_i),
  .quire_i (quire_q),
  .res_i   (res_o)
);

//--- verification/core_op_patterns.txt
# name kind op | s1 te1 m1 | s2 te2 m2 | s3 te3 m3 | exp_sign exp_te exp_frac exp_flag
# kind 0 drive, 1 check, 2 reset, 3 idle; op 0 ADD 1 SUB 2 MUL 3 DIV 4 FMADD 5 FMREAD
add_same_te      1 0 0 0 1800 0 0 1400 0 0 1000 0 1 1800000 0
add_lost_bits    1 0 0 0 1000 0 -3 1003 0 0 1000 0 0 0800000 1
sub_cancel       1 1 0 1 1b40 0 1 1900 0 0 1000 0 -2 0800000 0
sub_negative     1 1 0 0 1000 0 2 1000 0 0 1000 1 1 2000000 0
sub_borrow       1 1 0 0 1000 0 -14 1800 0 0 1000 0 -1 3ffc000 1
idle_a           3 0 0 0 1000 0 0 1000 0 0 1000 0 0 0 0
mul_ovf_sign     1 2 1 0 1800 0 1 1800 0 0 1000 1 2 0800000 0
mul_ovf_flag     1 2 1 -1 1fff 1 3 1fff 0 0 1000 0 3 3ff8000 1
mul_no_ovf       1 2 0 2 1400 1 -5 1200 0 0 1000 1 -3 1a00000 0
div_exact        1 3 0 3 1e00 1 1 1400 0 0 1000 1 2 2000000 0
div_third        1 3 0 0 1000 0 1 1800 0 0 1000 0 -2 1555555 1
fma1_step1       0 4 0 0 1800 0 1 1000 0 2 1000 0 0 0 0
fma1_step2       0 4 0 0 1400 0 0 1000 0 5 1000 0 0 0 0
fma1_step3       0 4 0 -1 1800 0 -1 1000 0 4 1000 0 0 0 0
fma1_read        1 5 0 0 1000 0 0 1000 0 0 1000 0 3 0500000 0
fma1_reread      1 5 0 0 1000 0 0 1000 0 0 1000 0 3 0500000 0
idle_b           3 0 0 0 1000 0 0 1000 0 0 1000 0 0 0 0
fma2_step1       0 4 1 0 1000 0 0 1000 1 1 1800 0 0 0 0
fma2_step2       0 4 0 0 1800 0 0 1800 0 3 1000 0 0 0 0
fma2_read        1 5 0 0 1000 0 0 1000 0 0 1000 1 0 3000000 0
reset_mid        2 0 0 0 1000 0 0 1000 0 0 1000 0 0 0 0
read_after_reset 1 5 0 0 1000 0 0 1000 0 0 1000 0 -32 0000000 0

//--- verification/core_op_tb.sv
`timescale 1ns/1ps

module core_op_tb;

  typedef enum logic [1:0] {
    STEP_DRIVE,  // Drive only.
    STEP_CHECK,  // Drive, then compare at the falling edge.
    STEP_RESET,  // Pulse rst_i for one cycle.
    STEP_IDLE    // Random non-FMADD op.
  } step_kind_e;

  typedef struct packed {
    step_kind_e          kind;
    ppu_pkg::operation_e op;
    ppu_pkg::fir_t       fir1;
    ppu_pkg::fir_t       fir2;
    ppu_pkg::fir_t       fir3;
    logic                exp_sign;
    ppu_pkg::exponent_t  exp_te;
    ppu_pkg::frac_full_t exp_frac;
    logic                exp_flag;
  } step_t;

  logic                clk_i = 1'b0;
  logic                rst_i;
  ppu_pkg::operation_e op_i;
  ppu_pkg::fir_t       fir1_i;
  ppu_pkg::fir_t       fir2_i;
  ppu_pkg::fir_t       fir3_i;
  logic                sign_o;
  ppu_pkg::exponent_t  te_o;
  ppu_pkg::frac_full_t frac_o;
  logic                frac_truncated_o;

  step_t steps[$];
  string names[$];
  int    cycle_count = 0;
  int    cycle_limit = 0;
  int    checks_done = 0;

  core_op UUT (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .op_i             (op_i),
    .fir1_i           (fir1_i),
    .fir2_i           (fir2_i),
    .fir3_i           (fir3_i),
    .sign_o           (sign_o),
    .te_o             (te_o),
    .frac_o           (frac_o),
    .frac_truncated_o (frac_truncated_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  // ==========================================================
  // Compare tasks
  // ==========================================================

  task automatic check_sign(input string test, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s: sign expected %0b, actual %0b", test, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic check_te(input string test, input ppu_pkg::exponent_t exp_v,
                          input ppu_pkg::exponent_t act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s: te expected %0d, actual %0d", test, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic check_frac(input string test, input ppu_pkg::frac_full_t exp_v,
                            input ppu_pkg::frac_full_t act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s: frac expected %h, actual %h", test, exp_v, act_v);
      abort_run();
    end
  endtask

  task automatic check_flag(input string test, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s: frac_truncated expected %0b, actual %0b", test, exp_v, act_v);
      abort_run();
    end
  endtask

  // ==========================================================
  // Pattern file
  // ==========================================================

  function automatic ppu_pkg::fir_t to_fir(input int sign, input int te, input int mant);
    ppu_pkg::fir_t f;
    f.sign           = sign[0];
    f.total_exponent = ppu_pkg::exponent_t'(te);
    f.mant           = ppu_pkg::mant_t'(mant);
    return f;
  endfunction

  task automatic load_patterns();
    int                fd;
    int                n;
    int                f [15];
    string             line;
    logic [8*24-1:0]   name_v;
    step_t             s;
    fd = $fopen("verification/core_op_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the patterns file verification/core_op_patterns.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;  // Blank or comment.
      end
      n = $sscanf(line, "%s %d %d %d %d %h %d %d %h %d %d %h %d %d %h %d", name_v,
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                  f[11], f[12], f[13], f[14]);
      if (n != 16) begin
        $display("Malformed line in the patterns file: %s", line);
        abort_run();
      end
      s.kind     = step_kind_e'(f[0]);
      s.op       = ppu_pkg::operation_e'(f[1]);
      s.fir1     = to_fir(f[2], f[3], f[4]);
      s.fir2     = to_fir(f[5], f[6], f[7]);
      s.fir3     = to_fir(f[8], f[9], f[10]);
      s.exp_sign = f[11][0];
      s.exp_te   = ppu_pkg::exponent_t'(f[12]);
      s.exp_frac = ppu_pkg::frac_full_t'(f[13]);
      s.exp_flag = f[14][0];
      steps.push_back(s);
      names.push_back(string'(name_v));
    end
    $fclose(fd);
  endtask

  task automatic apply_step(input step_t s);
    rst_i  <= (s.kind == STEP_RESET);
    op_i   <= (s.kind == STEP_IDLE) ? ppu_pkg::operation_e'($urandom % 4) : s.op;
    fir1_i <= s.fir1;
    fir2_i <= s.fir2;
    fir3_i <= s.fir3;
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      abort_run();
    end
  end

  initial begin
    void'($urandom(88));
    rst_i  = 1'b1;
    op_i   = ppu_pkg::ADD;
    fir1_i = '0;
    fir2_i = '0;
    fir3_i = '0;
    load_patterns();
    cycle_limit = steps.size() + 10 + 20;  // Steps, reset cycles, slack.
    repeat (10) @(posedge clk_i);
    for (int i = 0; i < steps.size(); i++) begin
      apply_step(steps[i]);
      @(negedge clk_i);
      if (steps[i].kind == STEP_CHECK) begin
        check_sign(names[i], steps[i].exp_sign, sign_o);
        check_te(names[i], steps[i].exp_te, te_o);
        check_frac(names[i], steps[i].exp_frac, frac_o);
        check_flag(names[i], steps[i].exp_flag, frac_truncated_o);
        checks_done++;
      end
      @(posedge clk_i);
    end
    if (checks_done > 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("The patterns file holds no check lines");
      abort_run();
    end
  end

endmodule
